// File: verilog/hyb_cache_pkg.sv
/* Hybrid cache memory definitions */

package hyb_cache_pkg;

  //////////////////////////////////////////////////
  // Geometry
  //////////////////////////////////////////////////

  // Number of sets and ways per set
  localparam int unsigned NUM_SETS       = 16;
  // Associativity, must stay a power of two for the pointer wrap
  localparam int unsigned NUM_WAYS       = 4;
  localparam int unsigned TAG_WIDTH      = 8;
  localparam int unsigned WORD_WIDTH     = 32;
  localparam int unsigned WORDS_PER_LINE = 4;
  localparam int unsigned LINE_WIDTH     = WORDS_PER_LINE * WORD_WIDTH;

  // Derived index widths
  localparam int unsigned SET_IDX_WIDTH  = $clog2(NUM_SETS);
  localparam int unsigned OFF_WIDTH      = $clog2(WORDS_PER_LINE);
  localparam int unsigned WAY_IDX_WIDTH  = $clog2(NUM_WAYS);

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  typedef logic [SET_IDX_WIDTH-1:0] set_idx_t;
  typedef logic [OFF_WIDTH-1:0]     word_off_t;
  typedef logic [TAG_WIDTH-1:0]     tag_t;
  typedef logic [WORD_WIDTH-1:0]    word_t;

  // Word 0 sits in the low bits of the line
  typedef logic [LINE_WIDTH-1:0]    line_t;

  // One bit per way, used for hits, masks and victims
  typedef logic [NUM_WAYS-1:0]      way_oh_t;
  typedef logic [WAY_IDX_WIDTH-1:0] way_idx_t;

  // Tag store entry, valid bit kept next to the tag
  typedef struct packed {
    logic valid;
    tag_t tag;
  } tag_entry_t;

endpackage

// File: verilog/way_array.sv
/* Per-way set storage */

`timescale 1ns/100ps

module way_array import hyb_cache_pkg::*; #(
  // Entry type held per set and way
  parameter type payload_t = logic
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Read port, all ways of one set
  input  logic                        rd_en_i,
  input  set_idx_t                    rd_idx_i,
  output payload_t [NUM_WAYS-1:0]     rd_data_o,
  // Write port, masked per way
  input  set_idx_t                    wr_idx_i,
  input  way_oh_t                     wr_mask_i,
  input  payload_t                    wr_data_i
);

  // Storage, one row per set holding every way
  payload_t [NUM_WAYS-1:0] mem_q [NUM_SETS];

  // Registered read row
  payload_t [NUM_WAYS-1:0] rd_row_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // Start empty so every valid bit reads zero
      for (int s = 0; s < NUM_SETS; s++) begin
        mem_q[s] <= '0;
      end
      rd_row_q <= '0;
    end else begin
      // Masked write, any number of ways at once
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (wr_mask_i[w]) begin
          mem_q[wr_idx_i][w] <= wr_data_i;
        end
      end
      // Capture the whole set on a read
      if (rd_en_i) begin
        rd_row_q <= mem_q[rd_idx_i];
      end
    end
  end

  // Row shows up one edge after the read index
  assign rd_data_o = rd_row_q;

endmodule

// File: verilog/tag_compare.sv
/* Per-way tag comparison */

`timescale 1ns/100ps

module tag_compare import hyb_cache_pkg::*; (
  // Registered tag entries of the looked-up set
  input  tag_entry_t [NUM_WAYS-1:0] entries_i,
  // Registered request tag
  input  tag_t                      tag_i,
  // Per-way hit and valid vectors
  output way_oh_t                   hit_oh_o,
  output way_oh_t                   valid_o
);

  //////////////////////////////////////////////////
  // Compare
  //////////////////////////////////////////////////

  // Raw tag match, before the valid bit
  way_oh_t tag_eq;

  always_comb begin
    tag_eq  = '0;
    valid_o = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      // Pull apart each entry
      valid_o[w] = entries_i[w].valid;
      tag_eq[w]  = (entries_i[w].tag == tag_i);
    end
  end

  // A hit needs both the valid bit and a matching tag
  // Refill never stores one tag in two valid ways, so this stays one-hot
  assign hit_oh_o = valid_o & tag_eq;

endmodule

// File: verilog/victim_select.sv
/* Victim way selection */

`timescale 1ns/100ps

module victim_select import hyb_cache_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  // Valid bits of the looked-up set
  input  way_oh_t valid_i,
  // Strobe from the response stage on a miss
  input  logic    advance_i,
  // Suggested way to refill
  output way_oh_t victim_oh_o
);

  // Round-robin pointer, used once the set is full
  way_idx_t rr_ptr_q;

  // Lowest invalid way
  way_idx_t free_idx;

  // Set has no free way
  logic all_valid;

  assign all_valid = &valid_i;

  //////////////////////////////////////////////////
  // Victim choice
  //////////////////////////////////////////////////

  always_comb begin
    free_idx = '0;
    // Walk down so the lowest free way wins
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!valid_i[w]) begin
        free_idx = way_idx_t'(w);
      end
    end

    victim_oh_o = '0;
    if (all_valid) begin
      victim_oh_o[rr_ptr_q] = 1'b1;
    end else begin
      victim_oh_o[free_idx] = 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Pointer state
  //////////////////////////////////////////////////

  // Moves only on misses to a full set, wraps at NUM_WAYS
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_ptr_q <= '0;
    end else if (advance_i && all_valid) begin
      rr_ptr_q <= rr_ptr_q + 1'b1;
    end
  end

endmodule

// File: verilog/flush_ctrl.sv
/* Sequential flush controller */

`timescale 1ns/100ps

module flush_ctrl import hyb_cache_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  // Flush request, ignored while busy
  input  logic     flush_i,
  // Flush in progress, holds off both channels
  output logic     busy_o,
  // Clear strobe and set for the tag store
  output logic     clr_en_o,
  output set_idx_t clr_idx_o,
  // One-cycle completion pulse
  output logic     flush_ack_o
);

  logic     busy_q;
  // All sets cleared, one settle cycle before the ack
  logic     last_q;
  logic     ack_q;
  // Set being cleared
  set_idx_t cnt_q;

  //////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      last_q <= 1'b0;
      ack_q  <= 1'b0;
      cnt_q  <= '0;
    end else begin
      ack_q <= 1'b0;
      if (!busy_q) begin
        // Idle, wait for a request
        if (flush_i) begin
          busy_q <= 1'b1;
          cnt_q  <= '0;
        end
      end else if (last_q) begin
        // Walk done, release the channels together with the ack
        busy_q <= 1'b0;
        last_q <= 1'b0;
        ack_q  <= 1'b1;
      end else begin
        // One set per cycle
        cnt_q <= cnt_q + 1'b1;
        if (cnt_q == set_idx_t'(NUM_SETS - 1)) begin
          last_q <= 1'b1;
        end
      end
    end
  end

  assign busy_o      = busy_q;
  assign clr_en_o    = busy_q & ~last_q;
  assign clr_idx_o   = cnt_q;
  assign flush_ack_o = ack_q;

endmodule

// File: verilog/hyb_cache_mem.sv
/* Set-associative cache memory top */

`timescale 1ns/100ps

module hyb_cache_mem import hyb_cache_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,

  // Read request
  input  logic      rd_valid_i,
  output logic      rd_ready_o,
  input  set_idx_t  rd_idx_i,
  input  tag_t      rd_tag_i,
  input  word_off_t rd_off_i,

  // Read response, fixed one cycle after acceptance
  output logic      rd_rvalid_o,
  output logic      rd_hit_o,
  output way_oh_t   rd_hit_oh_o,
  output word_t     rd_data_o,
  output way_oh_t   rd_victim_oh_o,

  // Line refill
  input  logic      wr_valid_i,
  output logic      wr_ready_o,
  input  set_idx_t  wr_idx_i,
  input  tag_t      wr_tag_i,
  input  way_oh_t   wr_way_i,   // way mask
  input  logic      wr_vld_i,   // valid value to store
  input  line_t     wr_data_i,

  // Flush
  input  logic      flush_i,
  output logic      flush_ack_o
);

  //////////////////////////////////////////////////
  // Internal signals
  //////////////////////////////////////////////////

  // Handshakes
  logic       rd_fire;
  logic       wr_fire;

  // Flush sequencer outputs
  logic       flush_busy;
  logic       clr_en;
  set_idx_t   clr_idx;

  // Tag store write port after the flush mux
  set_idx_t   tag_wr_idx;
  way_oh_t    tag_wr_mask;
  tag_entry_t tag_wr_entry;

  // Data store write mask
  way_oh_t    data_wr_mask;

  // Registered set contents
  tag_entry_t [NUM_WAYS-1:0] tag_row;
  line_t      [NUM_WAYS-1:0] data_row;

  // Response stage
  logic       rsp_valid_q;
  tag_t       rsp_tag_q;
  word_off_t  rsp_off_q;
  way_oh_t    hit_oh;
  way_oh_t    set_valid;
  line_t      hit_line;

  //////////////////////////////////////////////////
  // Arbitration
  //////////////////////////////////////////////////

  // Flush blocks everything, writes win over reads
  assign wr_ready_o = ~flush_busy;
  assign rd_ready_o = ~flush_busy & ~wr_valid_i;

  assign wr_fire = wr_valid_i & wr_ready_o;
  assign rd_fire = rd_valid_i & rd_ready_o;

  // Flush clear takes the tag write port
  always_comb begin
    if (clr_en) begin
      tag_wr_idx         = clr_idx;
      tag_wr_mask        = '1;
      tag_wr_entry.valid = 1'b0;
      tag_wr_entry.tag   = '0;
    end else begin
      tag_wr_idx         = wr_idx_i;
      tag_wr_mask        = wr_fire ? wr_way_i : '0;
      tag_wr_entry.valid = wr_vld_i;
      tag_wr_entry.tag   = wr_tag_i;
    end
  end

  // Data is never cleared, a miss masks it anyway
  assign data_wr_mask = wr_fire ? wr_way_i : '0;

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  way_array #(
    .payload_t (tag_entry_t)
  ) tag_store (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .rd_en_i   (rd_fire),
    .rd_idx_i  (rd_idx_i),
    .rd_data_o (tag_row),
    .wr_idx_i  (tag_wr_idx),
    .wr_mask_i (tag_wr_mask),
    .wr_data_i (tag_wr_entry)
  );

  way_array #(
    .payload_t (line_t)
  ) data_store (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .rd_en_i   (rd_fire),
    .rd_idx_i  (rd_idx_i),
    .rd_data_o (data_row),
    .wr_idx_i  (wr_idx_i),
    .wr_mask_i (data_wr_mask),
    .wr_data_i (wr_data_i)
  );

  //////////////////////////////////////////////////
  // Response stage
  //////////////////////////////////////////////////

  // Request fields follow the set row by one edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
      rsp_tag_q   <= '0;
      rsp_off_q   <= '0;
    end else begin
      rsp_valid_q <= rd_fire;
      if (rd_fire) begin
        rsp_tag_q <= rd_tag_i;
        rsp_off_q <= rd_off_i;
      end
    end
  end

  tag_compare i_tag_compare (
    .entries_i (tag_row),
    .tag_i     (rsp_tag_q),
    .hit_oh_o  (hit_oh),
    .valid_o   (set_valid)
  );

  // Pointer moves on each missing response
  victim_select i_victim_select (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .valid_i     (set_valid),
    .advance_i   (rsp_valid_q & ~rd_hit_o),
    .victim_oh_o (rd_victim_oh_o)
  );

  // OR of hit lines, all zero on a miss
  always_comb begin
    hit_line = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (hit_oh[w]) begin
        hit_line = hit_line | data_row[w];
      end
    end
  end

  assign rd_rvalid_o = rsp_valid_q;
  assign rd_hit_oh_o = hit_oh;
  assign rd_hit_o    = |hit_oh;
  assign rd_data_o   = hit_line[rsp_off_q * WORD_WIDTH +: WORD_WIDTH];

  //////////////////////////////////////////////////
  // Flush
  //////////////////////////////////////////////////

  flush_ctrl i_flush_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .busy_o      (flush_busy),
    .clr_en_o    (clr_en),
    .clr_idx_o   (clr_idx),
    .flush_ack_o (flush_ack_o)
  );

endmodule

// File: testbench/cache_model.svh
/* Cache reference model */

`ifndef CACHE_MODEL_SVH
`define CACHE_MODEL_SVH

// Mirror of the tag, valid and data arrays
tag_t        m_tag  [NUM_SETS][NUM_WAYS];
logic        m_vld  [NUM_SETS][NUM_WAYS];
line_t       m_line [NUM_SETS][NUM_WAYS];
// Round-robin pointer, one for the whole cache
int unsigned m_rr;

task automatic model_reset();
  for (int s = 0; s < NUM_SETS; s++) begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      m_tag[s][w]  = '0;
      m_vld[s][w]  = 1'b0;
      m_line[s][w] = '0;
    end
  end
  m_rr = 0;
endtask

// Refill of every masked way in one set
task automatic model_write(set_idx_t idx, tag_t tag, way_oh_t mask, logic vld, line_t line);
  for (int w = 0; w < NUM_WAYS; w++) begin
    if (mask[w]) begin
      m_tag[idx][w]  = tag;
      m_vld[idx][w]  = vld;
      m_line[idx][w] = line;
    end
  end
endtask

// Flush only drops valid bits
task automatic model_flush();
  for (int s = 0; s < NUM_SETS; s++) begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      m_vld[s][w] = 1'b0;
    end
  end
endtask

function automatic way_oh_t model_hit_oh(set_idx_t idx, tag_t tag);
  way_oh_t hit;
  hit = '0;
  for (int w = 0; w < NUM_WAYS; w++) begin
    hit[w] = m_vld[idx][w] && (m_tag[idx][w] == tag);
  end
  return hit;
endfunction

// Addressed word of the hit line, zero on a miss
function automatic word_t model_word(set_idx_t idx, tag_t tag, word_off_t off);
  way_oh_t hit;
  hit = model_hit_oh(idx, tag);
  for (int w = 0; w < NUM_WAYS; w++) begin
    if (hit[w]) begin
      return word_t'(m_line[idx][w] >> (off * WORD_WIDTH));
    end
  end
  return '0;
endfunction

// First free way, else the pointer; a miss on a full set moves the pointer
task automatic model_victim(input set_idx_t idx, input logic hit, output way_oh_t victim);
  victim = '0;
  for (int w = 0; w < NUM_WAYS && victim == '0; w++) begin
    if (!m_vld[idx][w]) victim[w] = 1'b1;
  end
  if (victim == '0) begin
    victim[m_rr] = 1'b1;
    if (!hit) m_rr = (m_rr + 1) % NUM_WAYS;
  end
endtask

`endif

// File: testbench/tb_hyb_cache_mem.sv
/* Cache memory testbench */

`timescale 1ns/100ps

module tb_hyb_cache_mem import hyb_cache_pkg::*; ();

  logic clk_i = 1'b0;
  logic rst_ni;
  // Read channel
  logic rd_valid_i;
  logic rd_ready_o;
  logic rd_rvalid_o;
  logic rd_hit_o;
  set_idx_t rd_idx_i;
  tag_t rd_tag_i;
  word_off_t rd_off_i;
  way_oh_t rd_hit_oh_o;
  way_oh_t rd_victim_oh_o;
  word_t rd_data_o;
  // Write channel
  logic wr_valid_i;
  logic wr_ready_o;
  logic wr_vld_i;
  set_idx_t wr_idx_i;
  tag_t wr_tag_i;
  way_oh_t wr_way_i;
  line_t wr_data_i;
  logic flush_i;
  logic flush_ack_o;

  // Prediction for the read accepted at the last edge
  logic rsp_due;
  way_oh_t exp_hit_oh;
  way_oh_t exp_victim;
  word_t exp_data;
  // Handshakes at the last edge
  logic rd_acc;
  logic wr_acc;
  // Flush progress in edges since the start edge
  logic flush_on;
  int flush_edges;
  int ack_count;
  int hit_count;
  // Last response seen
  way_oh_t last_victim;
  logic last_hit;

  `include "cache_model.svh"

  hyb_cache_mem uut (.*);

  always #2 clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // Checking
  //////////////////////////////////////////////////

  task automatic stop_on_error();
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic expect_eq(string name, logic [LINE_WIDTH-1:0] got, logic [LINE_WIDTH-1:0] exp);
    assert (got === exp) else begin
      $display("Fail at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic report_timeout(string what);
    $display("Timeout while waiting for %s", what);
    stop_on_error();
  endtask

  // One clock with handshakes sampled late in the cycle and outputs checked at the falling edge
  task automatic tick();
    logic start_flush;
    logic busy_exp;
    #1;
    busy_exp = flush_on && (flush_edges <= NUM_SETS);
    expect_eq("wr_ready_o", wr_ready_o, !busy_exp);
    expect_eq("rd_ready_o", rd_ready_o, !busy_exp && !wr_valid_i);
    wr_acc = wr_valid_i && wr_ready_o;
    rd_acc = rd_valid_i && rd_ready_o;
    start_flush = flush_i && !flush_on;
    // Model order within one edge is write then read lookup then flush start
    if (wr_acc) model_write(wr_idx_i, wr_tag_i, wr_way_i, wr_vld_i, wr_data_i);
    if (rd_acc) begin
      exp_hit_oh = model_hit_oh(rd_idx_i, rd_tag_i);
      exp_data   = model_word(rd_idx_i, rd_tag_i, rd_off_i);
      model_victim(rd_idx_i, |exp_hit_oh, exp_victim);
    end
    rsp_due = rd_acc;
    if (start_flush) model_flush();
    @(posedge clk_i);
    if (flush_on) flush_edges++;
    if (start_flush) begin
      flush_on    = 1'b1;
      flush_edges = 0;
    end
    @(negedge clk_i);
    expect_eq("rd_rvalid_o", rd_rvalid_o, rsp_due);
    if (rsp_due) begin
      expect_eq("rd_hit_o", rd_hit_o, |exp_hit_oh);
      expect_eq("rd_hit_oh_o", rd_hit_oh_o, exp_hit_oh);
      expect_eq("rd_data_o", rd_data_o, exp_data);
      expect_eq("rd_victim_oh_o", rd_victim_oh_o, exp_victim);
      last_victim = rd_victim_oh_o;
      last_hit    = rd_hit_o;
      if (rd_hit_o) hit_count++;
    end
    expect_eq("flush_ack_o", flush_ack_o, flush_on && (flush_edges == NUM_SETS + 1));
    if (flush_ack_o) ack_count++;
    if (flush_on && (flush_edges == NUM_SETS + 1)) begin
      flush_on = 1'b0;
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic idle(int n);
    repeat (n) tick();
  endtask

  task automatic issue_read(set_idx_t idx, tag_t tag, word_off_t off);
    int n;
    rd_valid_i = 1'b1;
    rd_idx_i   = idx;
    rd_tag_i   = tag;
    rd_off_i   = off;
    tick();
    for (n = 1; !rd_acc; n++) begin
      if (n >= 64) report_timeout("rd_ready_o");
      tick();
    end
    rd_valid_i = 1'b0;
  endtask

  task automatic issue_write(set_idx_t idx, tag_t tag, way_oh_t mask, logic vld, line_t line);
    int n;
    wr_valid_i = 1'b1;
    wr_idx_i   = idx;
    wr_tag_i   = tag;
    wr_way_i   = mask;
    wr_vld_i   = vld;
    wr_data_i  = line;
    tick();
    for (n = 1; !wr_acc; n++) begin
      if (n >= 64) report_timeout("wr_ready_o");
      tick();
    end
    wr_valid_i = 1'b0;
  endtask

  task automatic wait_flush_done();
    int n;
    for (n = 0; flush_on; n++) begin
      if (n >= 64) report_timeout("flush_ack_o");
      tick();
    end
  endtask

  function automatic line_t rand_line();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  function automatic way_oh_t rotl(way_oh_t v);
    return {v[NUM_WAYS-2:0], v[NUM_WAYS-1]};
  endfunction

  // Valid refills go to one way and reuse the way that already holds the tag
  task automatic rand_write();
    set_idx_t idx;
    tag_t tag;
    logic vld;
    int way;
    way_oh_t mask;
    idx  = set_idx_t'($urandom);
    tag  = tag_t'($urandom_range(7));
    vld  = ($urandom_range(9) < 7);
    mask = way_oh_t'($urandom);
    if (vld) begin
      way = $urandom_range(NUM_WAYS - 1);
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (m_vld[idx][w] && m_tag[idx][w] == tag) way = w;
      end
      mask = way_oh_t'(1) << way;
    end
    issue_write(idx, tag, mask, vld, rand_line());
  endtask

  // Half of the reads reuse a stored tag to raise the hit rate
  task automatic rand_read();
    set_idx_t idx;
    tag_t tag;
    idx = set_idx_t'($urandom);
    tag = tag_t'($urandom_range(7));
    if ($urandom_range(1)) tag = m_tag[idx][$urandom_range(NUM_WAYS - 1)];
    issue_read(idx, tag, word_off_t'($urandom));
  endtask

  initial begin
    way_oh_t prev;
    int hits_before;
    void'($urandom(32'h8b71));
    rst_ni = 1'b0;
    rd_valid_i = 1'b0;
    rd_idx_i = '0;
    rd_tag_i = '0;
    rd_off_i = '0;
    wr_valid_i = 1'b0;
    wr_idx_i = '0;
    wr_tag_i = '0;
    wr_way_i = '0;
    wr_vld_i = 1'b0;
    wr_data_i = '0;
    flush_i = 1'b0;
    rsp_due = 1'b0;
    rd_acc = 1'b0;
    wr_acc = 1'b0;
    flush_on = 1'b0;
    flush_edges = 0;
    ack_count = 0;
    hit_count = 0;
    model_reset();
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // Back-to-back misses on the empty cache
    for (int i = 0; i < 8; i++) begin
      issue_read(set_idx_t'($urandom), tag_t'($urandom_range(7)), word_off_t'($urandom));
    end
    idle(2);

    // Random refills and lookups
    for (int i = 0; i < 400; i++) begin
      if ($urandom_range(2) == 0) rand_write();
      else rand_read();
    end
    idle(1);
    assert (hit_count > 0) else begin
      $display("No read hit during the random traffic");
      stop_on_error();
    end

    // Misses on a full set walk the ways in order and a hit holds the pointer
    issue_write(5, 8'h00, '1, 1'b0, '0);
    for (int w = 0; w < NUM_WAYS; w++) begin
      issue_write(5, tag_t'(8'h10 + w), way_oh_t'(1) << w, 1'b1, rand_line());
    end
    issue_read(5, 8'h20, 0);
    idle(1);
    prev = exp_victim;
    for (int i = 0; i < 5; i++) begin
      issue_read(5, 8'h20, word_off_t'(i));
      idle(1);
      expect_eq("rd_victim_oh_o", last_victim, rotl(prev));
      prev = exp_victim;
    end
    issue_read(5, 8'h11, 1);
    idle(1);
    expect_eq("rd_hit_o", last_hit, 1'b1);
    issue_read(5, 8'h20, 2);
    idle(1);
    expect_eq("rd_victim_oh_o", last_victim, rotl(prev));
    issue_write(5, 8'h12, 4'b0100, 1'b0, '0);
    issue_read(5, 8'h20, 3);
    idle(1);
    expect_eq("rd_victim_oh_o", last_victim, 4'b0100);

    // Write and read in the same cycle with the write going first
    issue_write(9, 8'h00, '1, 1'b0, '0);
    rd_valid_i = 1'b1;
    rd_idx_i   = 9;
    rd_tag_i   = 3;
    rd_off_i   = 2;
    wr_valid_i = 1'b1;
    wr_idx_i   = 9;
    wr_tag_i   = 3;
    wr_way_i   = 4'b0010;
    wr_vld_i   = 1'b1;
    wr_data_i  = rand_line();
    tick();
    expect_eq("wr_ready_o", wr_acc, 1'b1);
    wr_valid_i = 1'b0;
    issue_read(9, 3, 2);
    idle(1);
    expect_eq("rd_hit_o", last_hit, 1'b1);

    // Flush with the request held past the start edge
    for (int i = 0; i < 40; i++) rand_write();
    flush_i = 1'b1;
    idle(5);
    flush_i = 1'b0;
    wait_flush_done();
    idle(2);
    expect_eq("flush_ack_o", ack_count, 1);
    hits_before = hit_count;
    for (int s = 0; s < NUM_SETS; s++) begin
      issue_read(set_idx_t'(s), m_tag[s][0], 0);
    end
    idle(1);
    expect_eq("rd_hit_o", hit_count - hits_before, 0);
    issue_write(3, 8'h04, 4'b0001, 1'b1, rand_line());
    issue_read(3, 8'h04, 1);
    idle(1);
    expect_eq("rd_hit_o", last_hit, 1'b1);

    $display("all tests passed");
    $finish;
  end

endmodule

// File: Bender.yml
package:
  name: hyb_cache_mem

sources:
  # Package first, then the leaf modules and the top
  - verilog/hyb_cache_pkg.sv
  - verilog/way_array.sv
  - verilog/tag_compare.sv
  - verilog/victim_select.sv
  - verilog/flush_ctrl.sv
  - verilog/hyb_cache_mem.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_hyb_cache_mem.sv

// File: files.f
+incdir+testbench
verilog/hyb_cache_pkg.sv
verilog/way_array.sv
verilog/tag_compare.sv
verilog/victim_select.sv
verilog/flush_ctrl.sv
verilog/hyb_cache_mem.sv
testbench/tb_hyb_cache_mem.sv
